/* src/csr_addr_pkg.sv */
package csr_addr_pkg;

  typedef logic [31:0] csr_word_t;
  typedef logic [11:0] csr_addr_t;

  typedef enum logic [1:0] {
    U_MODE        = 2'd0,
    S_MODE        = 2'd1,
    RESERVED_MODE = 2'd2,
    M_MODE        = 2'd3
  } priv_level_e;

  typedef enum logic [1:0] {
    CSR_NONE  = 2'd0,
    CSR_WRITE = 2'd1,
    CSR_SET   = 2'd2,
    CSR_CLEAR = 2'd3
  } csr_op_e;

  // One access from the core
  typedef struct packed {
    csr_addr_t addr;
    csr_op_e   op;
    csr_word_t src;
  } csr_req_t;

  // Checked write towards the register stores
  typedef struct packed {
    logic      en;
    csr_addr_t addr;
    csr_word_t val;
  } csr_write_t;

  // Machine information, read only
  localparam csr_addr_t MVENDORID_ADDR     = 12'hF11;
  localparam csr_addr_t MARCHID_ADDR       = 12'hF12;
  localparam csr_addr_t MIMPID_ADDR        = 12'hF13;
  localparam csr_addr_t MHARTID_ADDR       = 12'hF14;
  localparam csr_addr_t MCONFIGPTR_ADDR    = 12'hF15;

  // Machine trap setup and handling
  localparam csr_addr_t MSTATUS_ADDR       = 12'h300;
  localparam csr_addr_t MISA_ADDR          = 12'h301;
  localparam csr_addr_t MIE_ADDR           = 12'h304;
  localparam csr_addr_t MTVEC_ADDR         = 12'h305;
  localparam csr_addr_t MCOUNTEREN_ADDR    = 12'h306;
  localparam csr_addr_t MSTATUSH_ADDR      = 12'h310;
  localparam csr_addr_t MCOUNTINHIBIT_ADDR = 12'h320;
  localparam csr_addr_t MSCRATCH_ADDR      = 12'h340;
  localparam csr_addr_t MEPC_ADDR          = 12'h341;
  localparam csr_addr_t MCAUSE_ADDR        = 12'h342;
  localparam csr_addr_t MTVAL_ADDR         = 12'h343;
  localparam csr_addr_t MIP_ADDR           = 12'h344;

  // Machine counters
  localparam csr_addr_t MCYCLE_ADDR        = 12'hB00;
  localparam csr_addr_t MINSTRET_ADDR      = 12'hB02;
  localparam csr_addr_t MCYCLEH_ADDR       = 12'hB80;
  localparam csr_addr_t MINSTRETH_ADDR     = 12'hB82;

  // User counter views, gated by mcounteren
  localparam csr_addr_t CYCLE_ADDR         = 12'hC00;
  localparam csr_addr_t TIME_ADDR          = 12'hC01;
  localparam csr_addr_t INSTRET_ADDR       = 12'hC02;
  localparam csr_addr_t CYCLEH_ADDR        = 12'hC80;
  localparam csr_addr_t TIMEH_ADDR         = 12'hC81;
  localparam csr_addr_t INSTRETH_ADDR      = 12'hC82;

endpackage

/* src/csr_types_pkg.sv */
package csr_types_pkg;

  // mstatus at ISA bit positions, S and extension fields tied off
  typedef struct packed {
    logic                      sd;          // 31, stays zero
    logic [8:0]                reserved_3;  // 30:22
    logic                      tw;          // 21
    logic [2:0]                reserved_2;  // 20:18
    logic                      mprv;        // 17
    logic [3:0]                reserved_1;  // 16:13, XS and FS
    csr_addr_pkg::priv_level_e mpp;         // 12:11
    logic [2:0]                reserved_0;  // 10:8
    logic                      mpie;        // 7
    logic [2:0]                reserved_m;  // 6:4
    logic                      mie;         // 3
    logic [2:0]                reserved_l;  // 2:0
  } mstatus_t;

  typedef enum logic [1:0] {
    DIRECT   = 2'd0,
    VECTORED = 2'd1
  } vec_mode_e;

  // Raw word for read back, fields for mode legalisation
  typedef union packed {
    csr_addr_pkg::csr_word_t raw;
    struct packed {
      logic [29:0] base;
      vec_mode_e   mode;
    } f;
  } mtvec_u;

  // mie and mip share one layout
  typedef struct packed {
    logic [19:0] reserved_h;
    logic        meie;        // 11
    logic [2:0]  reserved_e;
    logic        mtie;        // 7
    logic [2:0]  reserved_t;
    logic        msie;        // 3
    logic [2:0]  reserved_s;
  } mint_t;

  typedef struct packed {
    logic [28:0] hpm;
    logic        ir;
    logic        tm;
    logic        cy;
  } counter_bits_t;

  // Next values driven by the exception handler
  typedef struct packed {
    logic                    inject_mstatus;
    logic                    inject_mepc;
    logic                    inject_mcause;
    logic                    inject_mtval;
    logic                    inject_mip;
    mstatus_t                next_mstatus;
    csr_addr_pkg::csr_word_t next_mepc;
    csr_addr_pkg::csr_word_t next_mcause;
    csr_addr_pkg::csr_word_t next_mtval;
    mint_t                   next_mip;
  } trap_update_t;

  typedef struct packed {
    mstatus_t                mstatus;
    mtvec_u                  mtvec;
    mint_t                   mie;
    mint_t                   mip;
    csr_addr_pkg::csr_word_t mepc;
    csr_addr_pkg::csr_word_t mcause;
  } csr_state_t;

  // RV32 base with I and U
  localparam csr_addr_pkg::csr_word_t MISA_VALUE = 32'h4010_0100;
  localparam mstatus_t MSTATUS_RESET = 32'h0020_0000;  // TW only

endpackage

/* src/csr_access_check.sv */
`timescale 1ns/100ps

module csr_access_check (
  input  logic                      CLK,
  input  logic                      nRST,
  input  csr_addr_pkg::csr_req_t    req,
  input  csr_addr_pkg::priv_level_e priv,
  input  csr_addr_pkg::csr_word_t   old_val,
  input  logic                      addr_invalid,
  output logic                      invalid,
  output csr_addr_pkg::csr_write_t  wr
);

  import csr_addr_pkg::*;

  logic      access;
  logic      pure_read;
  logic      ro_fault;
  logic      priv_fault;
  csr_word_t new_val;

  assign access    = (req.op != CSR_NONE);
  // Set or clear of nothing only reads
  assign pure_read = ((req.op == CSR_SET) || (req.op == CSR_CLEAR)) && (req.src == '0);

  always_comb begin
    case (req.op)
      CSR_WRITE: new_val = req.src;
      CSR_SET:   new_val = req.src | old_val;
      CSR_CLEAR: new_val = old_val & ~req.src;
      default:   new_val = req.src;
    endcase
  end

  assign ro_fault   = access && (req.addr[11:10] == 2'b11) && !pure_read;
  assign priv_fault = access && (req.addr[9:8] > priv);  // Address needs more privilege

  // Unknown or gated addresses from the read mux only count with an access
  assign invalid = access && (ro_fault || priv_fault || addr_invalid);

  assign wr.en   = access && !ro_fault && !priv_fault;
  assign wr.addr = req.addr;
  assign wr.val  = new_val;

  // Read-only space only passes as a pure read, so the value stays as it was
  a_ro_unchanged: assert property (@(posedge CLK) disable iff (!nRST)
    (wr.en && (wr.addr[11:10] == 2'b11)) |-> (wr.val == old_val));

endmodule

/* src/csr_trap_regs.sv */
`timescale 1ns/100ps

module csr_trap_regs (
  input  logic                         CLK,
  input  logic                         nRST,
  input  csr_addr_pkg::csr_write_t     wr,
  input  csr_types_pkg::trap_update_t  trap,
  output csr_types_pkg::csr_state_t    state,
  output csr_addr_pkg::csr_word_t      scratch,
  output csr_addr_pkg::csr_word_t      tval
);

  import csr_addr_pkg::*;
  import csr_types_pkg::*;

  mstatus_t  mstatus, mstatus_next;
  mtvec_u    mtvec, mtvec_next;
  mint_t     mie, mie_next;
  mint_t     mip, mip_next;
  csr_word_t mscratch, mscratch_next;
  csr_word_t mepc, mepc_next;
  csr_word_t mcause, mcause_next;
  csr_word_t mtval, mtval_next;
  mstatus_t  wr_st;

  assign wr_st = wr.val;

  // Machine interrupt bits only
  function automatic mint_t keep_mint(input csr_word_t v);
    mint_t src;
    mint_t res;
    src      = v;
    res      = '0;
    res.msie = src.msie;
    res.mtie = src.mtie;
    res.meie = src.meie;
    return res;
  endfunction

  always_comb begin
    mstatus_next  = mstatus;
    mtvec_next    = mtvec;
    mie_next      = mie;
    mip_next      = mip;
    mscratch_next = mscratch;
    mepc_next     = mepc;
    mcause_next   = mcause;
    mtval_next    = mtval;

    if (wr.en) begin
      case (wr.addr)
        MSTATUS_ADDR: begin
          mstatus_next      = '0;
          mstatus_next.mie  = wr_st.mie;
          mstatus_next.mpie = wr_st.mpie;
          mstatus_next.mprv = wr_st.mprv;
          mstatus_next.tw   = wr_st.tw;
          // No S mode, so S and reserved fall back to U
          if (wr_st.mpp == M_MODE) begin
            mstatus_next.mpp = M_MODE;
          end else begin
            mstatus_next.mpp = U_MODE;
          end
        end
        MTVEC_ADDR: begin
          mtvec_next.raw = wr.val;
          if (mtvec_next.f.mode > VECTORED) begin
            mtvec_next.f.mode = DIRECT;
          end
        end
        MIE_ADDR:      mie_next      = keep_mint(wr.val);
        MIP_ADDR:      mip_next      = keep_mint(wr.val);
        MSCRATCH_ADDR: mscratch_next = wr.val;
        MEPC_ADDR:     mepc_next     = wr.val;
        MCAUSE_ADDR:   mcause_next   = wr.val;
        MTVAL_ADDR:    mtval_next    = wr.val;
        default: ;
      endcase
    end

    // Trap logic wins over software at the same edge
    if (trap.inject_mstatus) mstatus_next = trap.next_mstatus;
    if (trap.inject_mepc)    mepc_next    = trap.next_mepc;
    if (trap.inject_mcause)  mcause_next  = trap.next_mcause;
    if (trap.inject_mtval)   mtval_next   = trap.next_mtval;
    if (trap.inject_mip)     mip_next     = trap.next_mip;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus <= MSTATUS_RESET;
      mtvec   <= '0;
      mie     <= '0;
      mip     <= '0;
      mcause  <= '0;
    end else begin
      mstatus <= mstatus_next;
      mtvec   <= mtvec_next;
      mie     <= mie_next;
      mip     <= mip_next;
      mcause  <= mcause_next;
    end
  end

  always_ff @(posedge CLK) begin
    mscratch <= mscratch_next;
    mepc     <= mepc_next;
    mtval    <= mtval_next;
  end

  assign state.mstatus = mstatus;
  assign state.mtvec   = mtvec;
  assign state.mie     = mie;
  assign state.mip     = mip;
  assign state.mepc    = mepc;
  assign state.mcause  = mcause;
  assign scratch       = mscratch;
  assign tval          = mtval;

  // Software writes are legalised here, injected values rely on the trap logic
  a_mpp_legal: assert property (@(posedge CLK) disable iff (!nRST)
    mstatus.mpp inside {U_MODE, M_MODE});

endmodule

/* src/csr_counters.sv */
`timescale 1ns/100ps

module csr_counters (
  input  logic                          CLK,
  input  logic                          nRST,
  input  csr_addr_pkg::csr_write_t      wr,
  input  logic                          inst_ret,
  output logic [63:0]                   cycle,
  output logic [63:0]                   instret,
  output csr_types_pkg::counter_bits_t  counteren,
  output csr_types_pkg::counter_bits_t  inhibit
);

  import csr_addr_pkg::*;
  import csr_types_pkg::*;

  logic [63:0]   cycle_next;
  logic [63:0]   instret_next;
  counter_bits_t counteren_next;
  counter_bits_t inhibit_next;
  logic          cycle_wr;

  assign cycle_wr = wr.en && ((wr.addr == MCYCLE_ADDR) || (wr.addr == MCYCLEH_ADDR));

  always_comb begin
    cycle_next     = inhibit.cy ? cycle : cycle + 64'd1;
    instret_next   = inhibit.ir ? instret : instret + {63'd0, inst_ret};
    counteren_next = counteren;
    inhibit_next   = inhibit;

    // Half writes replace the increment
    if (wr.en) begin
      case (wr.addr)
        MCYCLE_ADDR:     cycle_next     = {cycle[63:32], wr.val};
        MCYCLEH_ADDR:    cycle_next     = {wr.val, cycle[31:0]};
        MINSTRET_ADDR:   instret_next   = {instret[63:32], wr.val};
        MINSTRETH_ADDR:  instret_next   = {wr.val, instret[31:0]};
        MCOUNTEREN_ADDR: counteren_next = wr.val;
        MCOUNTINHIBIT_ADDR: begin
          inhibit_next    = wr.val;
          inhibit_next.tm = 1'b0;  // time cannot be inhibited
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cycle     <= '0;
      instret   <= '0;
      counteren <= '1;
      inhibit   <= '0;
    end else begin
      cycle     <= cycle_next;
      instret   <= instret_next;
      counteren <= counteren_next;
      inhibit   <= inhibit_next;
    end
  end

  a_cycle_step: assert property (@(posedge CLK) disable iff (!nRST)
    (!inhibit.cy && !cycle_wr) |=> (cycle == $past(cycle) + 64'd1));

endmodule

/* src/csr_read_mux.sv */
`timescale 1ns/100ps

module csr_read_mux #(
  parameter int unsigned HART_ID = 0
) (
  input  csr_addr_pkg::csr_addr_t       addr,
  input  csr_addr_pkg::priv_level_e     priv,
  input  csr_types_pkg::csr_state_t     state,
  input  csr_addr_pkg::csr_word_t       scratch,
  input  csr_addr_pkg::csr_word_t       tval,
  input  logic [63:0]                   cycle,
  input  logic [63:0]                   instret,
  input  logic [63:0]                   mtime,
  input  csr_types_pkg::counter_bits_t  counteren,
  input  csr_types_pkg::counter_bits_t  inhibit,
  output csr_addr_pkg::csr_word_t       old_val,
  output logic                          addr_invalid
);

  import csr_addr_pkg::*;
  import csr_types_pkg::*;

  logic user_mode;

  assign user_mode = (priv == U_MODE);

  always_comb begin
    old_val      = '0;
    addr_invalid = 1'b0;
    case (addr)
      MVENDORID_ADDR, MARCHID_ADDR, MIMPID_ADDR, MCONFIGPTR_ADDR: old_val = '0;
      MHARTID_ADDR:       old_val = csr_word_t'(HART_ID);
      MSTATUS_ADDR:       old_val = state.mstatus;
      MISA_ADDR:          old_val = MISA_VALUE;
      MIE_ADDR:           old_val = state.mie;
      MTVEC_ADDR:         old_val = state.mtvec.raw;
      MSTATUSH_ADDR:      old_val = '0;  // Little endian only
      MSCRATCH_ADDR:      old_val = scratch;
      MEPC_ADDR:          old_val = state.mepc;
      MCAUSE_ADDR:        old_val = state.mcause;
      MTVAL_ADDR:         old_val = tval;
      MIP_ADDR:           old_val = state.mip;
      MCOUNTEREN_ADDR:    old_val = counteren;
      MCOUNTINHIBIT_ADDR: old_val = inhibit;
      MCYCLE_ADDR:        old_val = cycle[31:0];
      MCYCLEH_ADDR:       old_val = cycle[63:32];
      MINSTRET_ADDR:      old_val = instret[31:0];
      MINSTRETH_ADDR:     old_val = instret[63:32];
      // User views read zero when gated
      CYCLE_ADDR, CYCLEH_ADDR: begin
        if (user_mode && !counteren.cy) begin
          addr_invalid = 1'b1;
        end else begin
          old_val = addr[7] ? cycle[63:32] : cycle[31:0];
        end
      end
      TIME_ADDR, TIMEH_ADDR: begin
        if (user_mode && !counteren.tm) begin
          addr_invalid = 1'b1;
        end else begin
          old_val = addr[7] ? mtime[63:32] : mtime[31:0];
        end
      end
      INSTRET_ADDR, INSTRETH_ADDR: begin
        if (user_mode && !counteren.ir) begin
          addr_invalid = 1'b1;
        end else begin
          old_val = addr[7] ? instret[63:32] : instret[31:0];
        end
      end
      default: addr_invalid = 1'b1;  // Nothing decodes here
    endcase
  end

endmodule

/* src/csr_file.sv */
`timescale 1ns/100ps

module csr_file #(
  parameter int unsigned HART_ID = 0
) (
  input  logic                         CLK,
  input  logic                         nRST,
  input  csr_addr_pkg::csr_req_t       req,
  input  csr_addr_pkg::priv_level_e    priv,
  input  logic                         inst_ret,
  input  logic [63:0]                  mtime,
  input  csr_types_pkg::trap_update_t  trap,
  output csr_addr_pkg::csr_word_t      old_val,
  output logic                         invalid,
  output csr_types_pkg::csr_state_t    state
);

  import csr_addr_pkg::*;
  import csr_types_pkg::*;

  logic          addr_invalid;
  csr_write_t    wr;
  csr_word_t     scratch;
  csr_word_t     tval;
  logic [63:0]   cycle;
  logic [63:0]   instret;
  counter_bits_t counteren;
  counter_bits_t inhibit;

  csr_access_check i_check (
    .CLK          (CLK),
    .nRST         (nRST),
    .req          (req),
    .priv         (priv),
    .old_val      (old_val),
    .addr_invalid (addr_invalid),
    .invalid      (invalid),
    .wr           (wr)
  );

  csr_trap_regs i_trap_regs (
    .CLK     (CLK),
    .nRST    (nRST),
    .wr      (wr),
    .trap    (trap),
    .state   (state),
    .scratch (scratch),
    .tval    (tval)
  );

  csr_counters i_counters (
    .CLK       (CLK),
    .nRST      (nRST),
    .wr        (wr),
    .inst_ret  (inst_ret),
    .cycle     (cycle),
    .instret   (instret),
    .counteren (counteren),
    .inhibit   (inhibit)
  );

  csr_read_mux #(
    .HART_ID (HART_ID)
  ) i_read_mux (
    .addr         (req.addr),
    .priv         (priv),
    .state        (state),
    .scratch      (scratch),
    .tval         (tval),
    .cycle        (cycle),
    .instret      (instret),
    .mtime        (mtime),
    .counteren    (counteren),
    .inhibit      (inhibit),
    .old_val      (old_val),
    .addr_invalid (addr_invalid)
  );

endmodule

/* verification/csr_file_tb.sv */
`timescale 1ns/100ps

module csr_file_tb;

  import csr_addr_pkg::*;
  import csr_types_pkg::*;

  localparam int MAX_CYCLES = 400;  // Roughly four times the length of all tests
  localparam int GAP        = 8;    // Cycles between two counter samples

  logic         CLK = 1'b0;
  logic         nRST;
  csr_req_t     req;
  priv_level_e  priv;
  logic         inst_ret;
  logic [63:0]  mtime;
  trap_update_t trap;
  csr_word_t    old_val;
  logic         invalid;
  csr_state_t   state;

  priv_level_e  mode;  // Privilege used by the next access
  integer       seed = 32'h1384_ac93;
  int           cycles = 0;

  csr_file #(
    .HART_ID (5)
  ) i_dut (
    .CLK      (CLK),
    .nRST     (nRST),
    .req      (req),
    .priv     (priv),
    .inst_ret (inst_ret),
    .mtime    (mtime),
    .trap     (trap),
    .old_val  (old_val),
    .invalid  (invalid),
    .state    (state)
  );

  always #10 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("test failed");
      $fatal(1, "Stopped by the cycle limit");
    end
  end

  task automatic check(input string name, input csr_word_t exp, input csr_word_t act);
    if (exp !== act) begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      $display("test failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // One request per falling edge, answer is combinational
  task automatic access(input csr_addr_t addr, input csr_op_e op, input csr_word_t src,
                        output csr_word_t rd, output logic inv);
    @(negedge CLK);
    priv     = mode;
    req.addr = addr;
    req.op   = op;
    req.src  = src;
    #1;
    rd  = old_val;
    inv = invalid;
  endtask

  // Set with zero source, a read that goes through the checks
  task automatic read_expect(input string name, input csr_addr_t addr, input csr_word_t exp);
    csr_word_t rd;
    logic      inv;
    access(addr, CSR_SET, '0, rd, inv);
    check(name, exp, rd);
    check({name, " invalid"}, 32'd0, 32'(inv));
  endtask

  // No operation, so counters keep counting
  task automatic peek(input csr_addr_t addr, output csr_word_t rd);
    logic inv;
    access(addr, CSR_NONE, '0, rd, inv);
  endtask

  task automatic write_csr(input csr_addr_t addr, input csr_word_t val);
    csr_word_t rd;
    logic      inv;
    access(addr, CSR_WRITE, val, rd, inv);
    check("write accepted", 32'd0, 32'(inv));
  endtask

  task automatic reset_info_reads;
    read_expect("mstatus", MSTATUS_ADDR, 32'h0020_0000);  // TW only
    read_expect("misa", MISA_ADDR, 32'h4010_0100);        // MXL 1 with I and U
    read_expect("mhartid", MHARTID_ADDR, 32'd5);
    read_expect("mvendorid", MVENDORID_ADDR, 32'd0);
    read_expect("mcounteren", MCOUNTEREN_ADDR, 32'hFFFF_FFFF);
  endtask

  task automatic scratch_operations;
    csr_word_t model;
    csr_word_t src;
    csr_word_t rd;
    logic      inv;
    src = $random(seed);
    write_csr(MSCRATCH_ADDR, src);
    model = src;
    repeat (6) begin
      src = $random(seed);
      access(MSCRATCH_ADDR, CSR_SET, src, rd, inv);
      check("mscratch before set", model, rd);
      check("mscratch set invalid", 32'd0, 32'(inv));
      model = model | src;
      src = $random(seed);
      access(MSCRATCH_ADDR, CSR_CLEAR, src, rd, inv);
      check("mscratch before clear", model, rd);
      model = model & ~src;
      src = $random(seed);
      access(MSCRATCH_ADDR, CSR_WRITE, src, rd, inv);
      check("mscratch before write", model, rd);
      model = src;
    end
    peek(MSCRATCH_ADDR, rd);
    check("mscratch", model, rd);
  endtask

  task automatic legal_value_rules;
    csr_word_t wv;
    wv      = $random(seed);
    wv[1:0] = 2'd2;
    write_csr(MTVEC_ADDR, wv);
    read_expect("mtvec mode 2", MTVEC_ADDR, {wv[31:2], 2'b00});
    wv      = $random(seed);
    wv[1:0] = 2'd3;
    write_csr(MTVEC_ADDR, wv);
    read_expect("mtvec mode 3", MTVEC_ADDR, {wv[31:2], 2'b00});
    write_csr(MSTATUS_ADDR, 32'h0000_0808);  // MPP S with MIE
    read_expect("mstatus mpp 1", MSTATUS_ADDR, 32'h0000_0008);
    write_csr(MSTATUS_ADDR, 32'h0000_1080);  // MPP reserved with MPIE
    read_expect("mstatus mpp 2", MSTATUS_ADDR, 32'h0000_0080);
    write_csr(MSTATUS_ADDR, 32'h0000_1800);
    read_expect("mstatus mpp 3", MSTATUS_ADDR, 32'h0000_1800);
    write_csr(MIE_ADDR, 32'hFFFF_FFFF);
    read_expect("mie", MIE_ADDR, 32'h0000_0888);  // MSI, MTI, MEI
  endtask

  task automatic invalid_accesses;
    csr_word_t rd;
    logic      inv;
    write_csr(MSCRATCH_ADDR, 32'h5A5A_0F0F);
    mode = U_MODE;
    access(MSCRATCH_ADDR, CSR_WRITE, 32'h1234_5678, rd, inv);
    check("user mscratch write invalid", 32'd1, 32'(inv));
    mode = M_MODE;
    peek(MSCRATCH_ADDR, rd);
    check("mscratch after user write", 32'h5A5A_0F0F, rd);
    access(CYCLE_ADDR, CSR_WRITE, 32'd1, rd, inv);
    check("read-only write invalid", 32'd1, 32'(inv));
    access(12'h7FF, CSR_SET, '0, rd, inv);
    check("unknown address invalid", 32'd1, 32'(inv));
    access(12'h7FF, CSR_NONE, '0, rd, inv);
    check("idle unknown address invalid", 32'd0, 32'(inv));
  endtask

  task automatic counter_behaviour;
    csr_word_t r1;
    csr_word_t r2;
    csr_word_t bits;
    logic      inv;
    int        pulses;
    peek(MCYCLE_ADDR, r1);
    repeat (GAP - 1) @(negedge CLK);
    peek(MCYCLE_ADDR, r2);
    check("mcycle step", 32'(GAP), r2 - r1);
    write_csr(MCOUNTINHIBIT_ADDR, 32'h0000_0001);  // Inhibit CY
    peek(MCYCLE_ADDR, r1);
    repeat (GAP - 1) @(negedge CLK);
    peek(MCYCLE_ADDR, r2);
    check("mcycle inhibited", 32'd0, r2 - r1);
    write_csr(MCOUNTINHIBIT_ADDR, 32'd0);
    peek(MINSTRET_ADDR, r1);
    pulses = 0;
    repeat (12) begin
      @(negedge CLK);
      bits     = $random(seed);
      inst_ret = bits[0];
      if (bits[0]) begin
        pulses++;
      end
    end
    @(negedge CLK);
    inst_ret = 1'b0;
    peek(MINSTRET_ADDR, r2);
    check("minstret pulses", 32'(pulses), r2 - r1);
    // User views with CY cleared in mcounteren
    access(MCOUNTEREN_ADDR, CSR_CLEAR, 32'd1, r1, inv);
    mode = U_MODE;
    access(CYCLE_ADDR, CSR_SET, '0, r1, inv);
    check("user cycle gated", 32'd1, 32'(inv));
    access(TIME_ADDR, CSR_SET, '0, r1, inv);
    check("user time", mtime[31:0], r1);
    check("user time invalid", 32'd0, 32'(inv));
    mode = M_MODE;
    write_csr(MCOUNTEREN_ADDR, 32'hFFFF_FFFF);
  endtask

  task automatic trap_injection;
    @(negedge CLK);
    priv              = mode;
    req.addr          = MEPC_ADDR;
    req.op            = CSR_WRITE;
    req.src           = 32'h0000_1000;
    trap.inject_mepc   = 1'b1;
    trap.next_mepc     = 32'h8000_0040;
    trap.inject_mcause = 1'b1;
    trap.next_mcause   = 32'h8000_000B;
    @(negedge CLK);
    trap   = '0;
    req.op = CSR_NONE;
    #1;
    check("state.mepc", 32'h8000_0040, state.mepc);
    check("state.mcause", 32'h8000_000B, state.mcause);
    read_expect("mepc", MEPC_ADDR, 32'h8000_0040);
    read_expect("mcause", MCAUSE_ADDR, 32'h8000_000B);
    @(negedge CLK);
    req.op          = CSR_NONE;
    trap.inject_mip = 1'b1;
    trap.next_mip   = 32'h0000_0080;  // Timer pending
    @(negedge CLK);
    trap = '0;
    #1;
    check("state.mip", 32'h0000_0080, state.mip);
    read_expect("mip", MIP_ADDR, 32'h0000_0080);
  endtask

  initial begin
    nRST     = 1'b0;
    req      = '0;
    priv     = M_MODE;
    mode     = M_MODE;
    inst_ret = 1'b0;
    mtime    = 64'h0000_0012_3456_789A;
    trap     = '0;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    reset_info_reads();
    scratch_operations();
    legal_value_rules();
    invalid_accesses();
    counter_behaviour();
    trap_injection();
    $display("test passed");
    $finish;
  end

endmodule

/* verilog.f */
src/csr_addr_pkg.sv
src/csr_types_pkg.sv
src/csr_access_check.sv
src/csr_trap_regs.sv
src/csr_counters.sv
src/csr_read_mux.sv
src/csr_file.sv
verification/csr_file_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CSR file testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module csr_file_tb \
  -Mdir obj_dir -o csr_file_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/csr_file_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0
